//--- bench/openmips_properties.sv
`timescale 1ns/1ps

module openmips_properties import mips_pkg::*; (
    input logic             clk,
    input logic             arst_n_i,
    input logic [reg_w-1:0] rom_addr_o,
    input logic             rom_ce_o,
    input logic [reg_w-1:0] ram_addr_o,
    input logic             ram_we_o,
    input logic             ram_ce_o
);

    // a write strobe is only valid with the ram selected.
    we_needs_ce: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_we_o |-> ram_ce_o)
        else $error("ram_we_o high while ram_ce_o is low");

    // word access only.
    ram_word_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_ce_o |-> (ram_addr_o[1:0] == 2'b00))
        else $error("ram_addr_o not word aligned");

    // the pc either holds for a stall or steps by one word.
    pc_hold_or_step: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rom_ce_o && $past(rom_ce_o)) |->
        ((rom_addr_o == $past(rom_addr_o)) ||
         (rom_addr_o == $past(rom_addr_o) + reg_w'(pc_step))))
        else $error("rom_addr_o neither held nor advanced by one step");

endmodule

bind openmips openmips_properties u_props (.*);

//--- bench/openmips_tb.sv
`timescale 1ns/1ps

module openmips_tb import mips_pkg::*; ();

    logic        clk;
    logic        arst_n_i;
    logic [31:0] rom_data;
    logic [31:0] ram_data;
    logic [31:0] rom_addr;
    logic        rom_ce;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic        ram_we;
    logic        ram_ce;

    logic [31:0] rom [256];
    logic [31:0] ram [64];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_pc [$];
    logic        wr_pend;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic        running;

    openmips uut (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rom_data_i (rom_data),
        .ram_data_i (ram_data),
        .rom_addr_o (rom_addr),
        .rom_ce_o   (rom_ce),
        .ram_addr_o (ram_addr),
        .ram_data_o (ram_wdata),
        .ram_we_o   (ram_we),
        .ram_ce_o   (ram_ce)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // past the rom the fetch sees nops.
    assign rom_data = (rom_ce && rom_addr < 32'd1024) ? rom[rom_addr[9:2]] : 32'h0;
    // the ram only answers while it is enabled.
    assign ram_data = ram_ce ? ram[ram_addr[7:2]] : 32'h0;

    function automatic logic [31:0] fill_word(input int a);
        return (32'(a) * 32'h9e3779b9) ^ 32'h00c0ffee;
    endfunction

    function automatic void source_use(input logic [31:0] w, output logic use_rs,
                                       output logic use_rt);
        logic [5:0] op;
        logic [5:0] fn;
        logic       r_ok;
        op = w[31:26];
        fn = w[5:0];
        r_ok = (fn inside {fn_sll, fn_srl, fn_sra, fn_addu, fn_subu, fn_and, fn_or,
                           fn_xor, fn_nor, fn_slt});
        use_rs = 1'b0;
        use_rt = 1'b0;
        if (op == op_special) begin
            use_rs = r_ok && !(fn inside {fn_sll, fn_srl, fn_sra});
            use_rt = r_ok;
        end else if (op inside {op_addiu, op_slti, op_andi, op_ori, op_xori, op_lw}) begin
            use_rs = 1'b1;
        end else if (op == op_sw) begin
            use_rs = 1'b1;
            use_rt = 1'b1;
        end
    endfunction

    // isa-level model that builds the expected store sequence and rom address trace.
    function automatic void reference_run();
        logic [31:0] r [32];
        logic [31:0] m [64];
        logic [31:0] w;
        logic [31:0] nxt;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] a;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic        urs;
        logic        urt;
        bit          stall [];
        int          n;
        n = prog.size();
        stall = new[n + 8];
        for (int k = 0; k < 32; k++) r[k] = 0;
        for (int k = 0; k < 64; k++) m[k] = fill_word(k);
        for (int i = 0; i < n; i++) begin
            w  = prog[i];
            op = w[31:26];
            rs = w[25:21];
            rt = w[20:16];
            sx = {{16{w[15]}}, w[15:0]};
            zx = {16'h0, w[15:0]};
            case (op)
                op_special: begin
                    case (w[5:0])
                        fn_addu: r[w[15:11]] = r[rs] + r[rt];
                        fn_subu: r[w[15:11]] = r[rs] - r[rt];
                        fn_and:  r[w[15:11]] = r[rs] & r[rt];
                        fn_or:   r[w[15:11]] = r[rs] | r[rt];
                        fn_xor:  r[w[15:11]] = r[rs] ^ r[rt];
                        fn_nor:  r[w[15:11]] = ~(r[rs] | r[rt]);
                        fn_slt:  r[w[15:11]] = ($signed(r[rs]) < $signed(r[rt])) ? 1 : 0;
                        fn_sll:  r[w[15:11]] = r[rt] << w[10:6];
                        fn_srl:  r[w[15:11]] = r[rt] >> w[10:6];
                        fn_sra:  r[w[15:11]] = $unsigned($signed(r[rt]) >>> w[10:6]);
                        default: ;
                    endcase
                end
                op_addiu: r[rt] = r[rs] + sx;
                op_slti:  r[rt] = ($signed(r[rs]) < $signed(sx)) ? 1 : 0;
                op_andi:  r[rt] = r[rs] & zx;
                op_ori:   r[rt] = r[rs] | zx;
                op_xori:  r[rt] = r[rs] ^ zx;
                op_lui:   r[rt] = {w[15:0], 16'h0};
                op_lw: begin
                    a = r[rs] + sx;
                    r[rt] = m[a[7:2]];
                end
                op_sw: begin
                    a = r[rs] + sx;
                    m[a[7:2]] = r[rt];
                    exp_addr.push_back(a);
                    exp_data.push_back(r[rt]);
                end
                default: ;
            endcase
            r[0] = 0;
            // a load feeding the very next instruction costs one cycle.
            nxt = (i + 1 < n) ? prog[i + 1] : 32'h0;
            source_use(nxt, urs, urt);
            stall[i] = (op == op_lw) && (rt != 0) &&
                       ((urs && nxt[25:21] == rt) || (urt && nxt[20:16] == rt));
        end
        for (int j = 0; j < n + 6; j++) begin
            exp_pc.push_back(32'(4 * j));
            if (j >= 2 && j - 2 < n && stall[j - 2]) begin
                exp_pc.push_back(32'(4 * j));
            end
        end
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input int rs, input int rt,
                                           input int rd, input int sh);
        return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input int rs, input int rt,
                                           input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic add_tail();
        for (int k = 1; k < 32; k++) begin
            prog.push_back(i_word(op_sw, 0, k, 4 * k));
        end
        repeat (4) prog.push_back(32'h0);
    endtask

    task automatic report_error(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
    endtask

    // samples at the falling edge and commits the ram write at the next rising edge.
    always @(negedge clk) begin
        wr_pend <= 1'b0;
        if (running && arst_n_i) begin
            if (rom_ce && exp_pc.size() > 0) begin
                assert (rom_addr == exp_pc[0]) else begin
                    report_error($sformatf("rom_addr_o %h, expected %h", rom_addr, exp_pc[0]));
                    $fatal(1);
                end
                void'(exp_pc.pop_front());
            end
            if (ram_we) begin
                assert (exp_addr.size() > 0) else begin
                    report_error("store seen with no store left in the reference");
                    $fatal(1);
                end
                assert (ram_addr == exp_addr[0] && ram_wdata == exp_data[0]) else begin
                    report_error($sformatf("store %h <- %h, expected %h <- %h", ram_addr,
                                           ram_wdata, exp_addr[0], exp_data[0]));
                    $fatal(1);
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                wr_pend <= 1'b1;
                wr_addr <= ram_addr;
                wr_data <= ram_wdata;
            end
        end
    end

    always @(posedge clk) begin
        if (wr_pend) begin
            ram[wr_addr[7:2]] <= wr_data;
        end
    end

    task automatic run_program(input string name);
        int limit;
        int cycles;
        for (int k = 0; k < 256; k++) rom[k] = (k < prog.size()) ? prog[k] : 32'h0;
        for (int k = 0; k < 64; k++) ram[k] = fill_word(k);
        exp_addr.delete();
        exp_data.delete();
        exp_pc.delete();
        reference_run();
        limit = 2 * prog.size() + 50;
        arst_n_i = 1'b0;
        repeat (2) @(negedge clk);
        assert (!rom_ce && !ram_ce && !ram_we && rom_addr == 0) else begin
            report_error("outputs not idle during reset");
            $fatal(1);
        end
        running  = 1'b1;
        arst_n_i = 1'b1;
        cycles   = 0;
        while (exp_addr.size() > 0 || exp_pc.size() > 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout in program %s: the pipeline stopped making progress", name);
                $display("RESULT: FAIL");
                $fatal(1);
            end
        end
        running = 1'b0;
        prog.delete();
    endtask

    initial begin
        int kind;
        logic [5:0] r_fns [10];
        logic [5:0] i_ops [6];
        r_fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sll, fn_srl,
                  fn_sra};
        i_ops = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
        arst_n_i = 1'b0;
        running  = 1'b0;
        wr_pend  = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        void'($urandom(32'hc143baf2));
        @(negedge clk);

        // forwarding from execute and memory followed by the register file bypass.
        prog.push_back(i_word(op_ori, 0, 1, 5));
        prog.push_back(r_word(fn_addu, 1, 1, 2, 0));
        prog.push_back(r_word(fn_addu, 1, 2, 3, 0));
        prog.push_back(r_word(fn_subu, 3, 1, 4, 0));
        prog.push_back(i_word(op_lui, 0, 5, 16'h8001));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(r_word(fn_sra, 0, 5, 6, 4));
        prog.push_back(r_word(fn_slt, 5, 4, 7, 0));
        prog.push_back(i_word(op_addiu, 0, 0, 16'h7777));
        prog.push_back(r_word(fn_or, 0, 4, 8, 0));
        add_tail();
        run_program("forwarding");

        // load followed directly by its consumer.
        prog.push_back(i_word(op_lw, 0, 9, 8));
        prog.push_back(r_word(fn_addu, 9, 9, 10, 0));
        prog.push_back(i_word(op_lw, 0, 11, 12));
        prog.push_back(i_word(op_sw, 0, 11, 16));
        prog.push_back(i_word(op_lw, 0, 12, 16));
        prog.push_back(r_word(fn_xor, 10, 12, 13, 0));
        add_tail();
        run_program("load_use");

        // random mix over the whole subset.
        for (int i = 0; i < 200; i++) begin
            kind = $urandom_range(0, 18);
            if (kind < 10) begin
                prog.push_back(r_word(r_fns[kind], $urandom_range(0, 31), $urandom_range(0, 31),
                                      $urandom_range(0, 31), $urandom_range(0, 31)));
            end else if (kind < 16) begin
                prog.push_back(i_word(i_ops[kind - 10], $urandom_range(0, 31),
                                      $urandom_range(0, 31), $urandom_range(0, 65535)));
            end else if (kind == 16) begin
                prog.push_back(i_word(op_lw, 0, $urandom_range(0, 31), 4 * $urandom_range(0, 63)));
            end else if (kind == 17) begin
                prog.push_back(i_word(op_sw, 0, $urandom_range(0, 31), 4 * $urandom_range(0, 63)));
            end else begin
                prog.push_back({6'h3f, 26'($urandom())});
            end
        end
        add_tail();
        run_program("random");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  stall_t                stall_i,
    input  inst_u                 inst_i,
    input  logic [reg_w-1:0]      rdata1_i,
    input  logic [reg_w-1:0]      rdata2_i,
    input  wb_t                   ex_fwd_i,
    input  wb_t                   mem_fwd_i,
    output logic [reg_addr_w-1:0] raddr1_o,
    output logic [reg_addr_w-1:0] raddr2_o,
    output logic                  re1_o,
    output logic                  re2_o,
    output id_ex_t                ex_o
);

    alu_op_e          alu_op;
    logic             r_ok;
    logic             shift_op;
    logic             use_imm;
    logic             zero_ext;
    logic             dest_rt;
    logic             we;
    logic             load;
    logic             store;
    logic [reg_w-1:0] imm_ext;
    logic [reg_w-1:0] rs_val;
    logic [reg_w-1:0] rt_val;
    id_ex_t           id_ex_d;

    always_comb begin
        alu_op   = alu_add;
        r_ok     = 1'b0;
        shift_op = 1'b0;
        use_imm  = 1'b0;
        zero_ext = 1'b0;
        dest_rt  = 1'b0;
        we       = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
        re1_o    = 1'b0;
        re2_o    = 1'b0;
        case (inst_i.r.opcode)
            op_special: begin
                r_ok = 1'b1;
                case (inst_i.r.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll: begin
                        alu_op   = alu_sll;
                        shift_op = 1'b1;
                    end
                    fn_srl: begin
                        alu_op   = alu_srl;
                        shift_op = 1'b1;
                    end
                    fn_sra: begin
                        alu_op   = alu_sra;
                        shift_op = 1'b1;
                    end
                    default: r_ok = 1'b0;
                endcase
                // shifts take the amount from shamt, not from rs.
                re1_o = r_ok && !shift_op;
                re2_o = r_ok;
                we    = r_ok;
            end
            op_addiu, op_slti, op_andi, op_ori, op_xori: begin
                re1_o    = 1'b1;
                we       = 1'b1;
                use_imm  = 1'b1;
                dest_rt  = 1'b1;
                zero_ext = (inst_i.i.opcode == op_andi) || (inst_i.i.opcode == op_ori) ||
                           (inst_i.i.opcode == op_xori);
                case (inst_i.i.opcode)
                    op_slti: alu_op = alu_slt;
                    op_andi: alu_op = alu_and;
                    op_ori:  alu_op = alu_or;
                    op_xori: alu_op = alu_xor;
                    default: alu_op = alu_add;
                endcase
            end
            op_lui: begin
                alu_op   = alu_lui;
                we       = 1'b1;
                use_imm  = 1'b1;
                zero_ext = 1'b1;
                dest_rt  = 1'b1;
            end
            op_lw: begin
                re1_o   = 1'b1;
                we      = 1'b1;
                use_imm = 1'b1;
                dest_rt = 1'b1;
                load    = 1'b1;
            end
            op_sw: begin
                re1_o   = 1'b1;
                re2_o   = 1'b1;
                use_imm = 1'b1;
                store   = 1'b1;
            end
            default: ;
        endcase
    end

    assign raddr1_o = inst_i.r.rs;
    assign raddr2_o = inst_i.r.rt;
    assign imm_ext  = zero_ext ? {16'b0, inst_i.i.imm} : {{16{inst_i.i.imm[15]}}, inst_i.i.imm};

    // execute result wins over memory, the register file covers writeback.
    function automatic logic [reg_w-1:0] fwd_pick(input logic re,
                                                   input logic [reg_addr_w-1:0] idx,
                                                   input logic [reg_w-1:0] rf_data);
        if (!re || idx == '0) begin
            return '0;
        end
        if (ex_fwd_i.we && ex_fwd_i.idx == idx) begin
            return ex_fwd_i.data;
        end
        if (mem_fwd_i.we && mem_fwd_i.idx == idx) begin
            return mem_fwd_i.data;
        end
        return rf_data;
    endfunction

    assign rs_val = fwd_pick(re1_o, raddr1_o, rdata1_i);
    assign rt_val = fwd_pick(re2_o, raddr2_o, rdata2_i);

    always_comb begin
        id_ex_d.alu_op     = alu_op;
        id_ex_d.a          = shift_op ? {{(reg_w-5){1'b0}}, inst_i.r.shamt} : rs_val;
        id_ex_d.b          = use_imm ? imm_ext : rt_val;
        id_ex_d.store_data = rt_val;
        id_ex_d.dest       = dest_rt ? inst_i.i.rt : inst_i.r.rd;
        id_ex_d.we         = we;
        id_ex_d.load       = load;
        id_ex_d.store      = store;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= '0;
        end else if (stall_i.bubble_ex) begin
            ex_o <= '0;
        end else begin
            ex_o <= id_ex_d;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  id_ex_t                ex_i,
    output wb_t                   fwd_o,
    output logic                  load_o,
    output logic [reg_addr_w-1:0] dest_o,
    output ex_mem_t               mem_o
);

    logic [reg_w-1:0] result;
    ex_mem_t          mem_d;

    always_comb begin
        case (ex_i.alu_op)
            alu_add: result = ex_i.a + ex_i.b;
            alu_sub: result = ex_i.a - ex_i.b;
            alu_and: result = ex_i.a & ex_i.b;
            alu_or:  result = ex_i.a | ex_i.b;
            alu_xor: result = ex_i.a ^ ex_i.b;
            alu_nor: result = ~(ex_i.a | ex_i.b);
            alu_slt: result = {{(reg_w-1){1'b0}}, $signed(ex_i.a) < $signed(ex_i.b)};
            alu_sll: result = ex_i.b << ex_i.a[4:0];
            alu_srl: result = ex_i.b >> ex_i.a[4:0];
            alu_sra: result = $unsigned($signed(ex_i.b) >>> ex_i.a[4:0]);
            alu_lui: result = {ex_i.b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    // a load only has its address here, so nothing to forward yet.
    assign fwd_o.we   = ex_i.we && !ex_i.load;
    assign fwd_o.idx  = ex_i.dest;
    assign fwd_o.data = result;

    assign load_o = ex_i.load;
    assign dest_o = ex_i.dest;

    always_comb begin
        mem_d.wb.we      = ex_i.we;
        mem_d.wb.idx     = ex_i.dest;
        mem_d.wb.data    = result;
        mem_d.store_data = ex_i.store_data;
        mem_d.load       = ex_i.load;
        mem_d.store      = ex_i.store;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_o <= '0;
        end else begin
            mem_o <= mem_d;
        end
    end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    input  stall_t           stall_i,
    input  logic [reg_w-1:0] rom_data_i,
    output logic [reg_w-1:0] rom_addr_o,
    output logic             rom_ce_o,
    output logic [reg_w-1:0] id_pc_o,
    output inst_u            id_inst_o
);

    logic [reg_w-1:0] pc;

    assign rom_addr_o = pc;

    // the rom enable comes up one edge after reset, the pc follows it.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_ce_o <= 1'b0;
            pc       <= '0;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i.hold_front) begin
                pc <= pc + reg_w'(pc_step);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o   <= '0;
            id_inst_o <= '0;
        end else if (!rom_ce_o) begin
            id_pc_o   <= '0;
            id_inst_o <= '0;
        end else if (!stall_i.hold_front) begin
            id_pc_o   <= pc;
            id_inst_o <= rom_data_i;
        end
    end

endmodule

//--- design/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    input  ex_mem_t          mem_i,
    input  logic [reg_w-1:0] ram_data_i,
    output logic [reg_w-1:0] ram_addr_o,
    output logic [reg_w-1:0] ram_data_o,
    output logic             ram_we_o,
    output logic             ram_ce_o,
    output wb_t              fwd_o,
    output wb_t              wb_o
);

    // loads and stores both carry the address in the result field.
    assign ram_addr_o = mem_i.wb.data;
    assign ram_data_o = mem_i.store_data;
    assign ram_ce_o   = mem_i.load || mem_i.store;
    assign ram_we_o   = mem_i.store;

    assign fwd_o.we   = mem_i.wb.we;
    assign fwd_o.idx  = mem_i.wb.idx;
    assign fwd_o.data = mem_i.load ? ram_data_i : mem_i.wb.data;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= fwd_o;
        end
    end

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

    localparam int reg_w      = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_num    = 32;
    localparam int pc_step    = 4;

    // primary opcodes.
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // function codes under op_special.
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    // one instruction word, read as R-type or I-type fields.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] idx;
        logic [reg_w-1:0]      data;
    } wb_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [reg_w-1:0]      a;
        logic [reg_w-1:0]      b;
        logic [reg_w-1:0]      store_data;
        logic [reg_addr_w-1:0] dest;
        logic                  we;
        logic                  load;
        logic                  store;
    } id_ex_t;

    typedef struct packed {
        wb_t              wb;
        logic [reg_w-1:0] store_data;
        logic             load;
        logic             store;
    } ex_mem_t;

    typedef struct packed {
        logic hold_front;
        logic bubble_ex;
    } stall_t;

endpackage

//--- design/openmips.sv
`timescale 1ns/1ps

module openmips import mips_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic [reg_w-1:0] rom_data_i,
    input  logic [reg_w-1:0] ram_data_i,
    output logic [reg_w-1:0] rom_addr_o,
    output logic             rom_ce_o,
    output logic [reg_w-1:0] ram_addr_o,
    output logic [reg_w-1:0] ram_data_o,
    output logic             ram_we_o,
    output logic             ram_ce_o
);

    stall_t                stall;
    inst_u                 id_inst;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic                  re1;
    logic                  re2;
    logic [reg_w-1:0]      rdata1;
    logic [reg_w-1:0]      rdata2;
    wb_t                   ex_fwd;
    wb_t                   mem_fwd;
    wb_t                   wb;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    logic                  ex_load;
    logic [reg_addr_w-1:0] ex_dest;

    pipe_ctrl u_pipe_ctrl (
        .rs_idx_i  (raddr1),
        .rt_idx_i  (raddr2),
        .rs_read_i (re1),
        .rt_read_i (re2),
        .ex_load_i (ex_load),
        .ex_dest_i (ex_dest),
        .stall_o   (stall)
    );

    fetch_stage u_fetch (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .id_pc_o    (),
        .id_inst_o  (id_inst)
    );

    decode_stage u_decode (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .stall_i   (stall),
        .inst_i    (id_inst),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .raddr1_o  (raddr1),
        .raddr2_o  (raddr2),
        .re1_o     (re1),
        .re2_o     (re2),
        .ex_o      (id_ex)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .re1_i    (re1),
        .re2_i    (re2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    execute_stage u_execute (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ex_i     (id_ex),
        .fwd_o    (ex_fwd),
        .load_o   (ex_load),
        .dest_o   (ex_dest),
        .mem_o    (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .mem_i      (ex_mem),
        .ram_data_i (ram_data_i),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_ce_o   (ram_ce_o),
        .fwd_o      (mem_fwd),
        .wb_o       (wb)
    );

endmodule

//--- design/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl import mips_pkg::*; (
    input  logic [reg_addr_w-1:0] rs_idx_i,
    input  logic [reg_addr_w-1:0] rt_idx_i,
    input  logic                  rs_read_i,
    input  logic                  rt_read_i,
    input  logic                  ex_load_i,
    input  logic [reg_addr_w-1:0] ex_dest_i,
    output stall_t                stall_o
);

    logic rs_hit;
    logic rt_hit;
    logic load_use;

    // the loaded word is only known once the load reaches memory.
    assign rs_hit   = rs_read_i && (rs_idx_i != '0) && (rs_idx_i == ex_dest_i);
    assign rt_hit   = rt_read_i && (rt_idx_i != '0) && (rt_idx_i == ex_dest_i);
    assign load_use = ex_load_i && (rs_hit || rt_hit);

    assign stall_o.hold_front = load_use;
    assign stall_o.bubble_ex  = load_use;

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  wb_t                   wb_i,
    input  logic [reg_addr_w-1:0] raddr1_i,
    input  logic [reg_addr_w-1:0] raddr2_i,
    input  logic                  re1_i,
    input  logic                  re2_i,
    output logic [reg_w-1:0]      rdata1_o,
    output logic [reg_w-1:0]      rdata2_o
);

    logic [reg_w-1:0] regs [reg_num];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.idx != '0) begin
            regs[wb_i.idx] <= wb_i.data;
        end
    end

    function automatic logic [reg_w-1:0] read_port(input logic re,
                                                    input logic [reg_addr_w-1:0] idx);
        if (!re || idx == '0) begin
            return '0;
        end
        // same-cycle write passes straight through.
        if (wb_i.we && wb_i.idx == idx) begin
            return wb_i.data;
        end
        return regs[idx];
    endfunction

    assign rdata1_o = read_port(re1_i, raddr1_i);
    assign rdata2_o = read_port(re2_i, raddr2_i);

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module openmips_tb -o openmips_sim
./obj_dir/openmips_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "RESULT: PASS" sim.log

//--- sim.f
design/mips_pkg.sv
design/pipe_ctrl.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/openmips.sv
bench/openmips_properties.sv
bench/openmips_tb.sv
